/* dv/breakout_tb.sv */
`timescale 1ns/10ps

module breakout_tb;
	localparam int scan_div = 2;
	localparam int move_div = 4;
	localparam int max_steps = 17;

	// keys are {sw_l, sw_r, shoot, pause}
	localparam logic [3:0] key_none = 4'b0000;
	localparam logic [3:0] key_left = 4'b1000;
	localparam logic [3:0] key_right = 4'b0100;
	localparam logic [3:0] key_both = 4'b1100;
	localparam logic [3:0] key_shoot = 4'b0010;
	localparam logic [3:0] key_pause = 4'b0001;

	typedef struct packed {
		logic sw_l;
		logic sw_r;
		logic shoot;
		logic pause;
		logic [3:0] back;
		logic [7:0] ticks;
		logic [2:0] lay;
		logic clr; // brick (4,2) already hit
		logic [2:0] pad;
		logic [2:0] bx;
		logic [2:0] by;
		logic [7:0] bar;
		logic [1:0] digit;
	} step_t;

	logic CLK;
	logic reset;
	logic sw_l;
	logic sw_r;
	logic shoot;
	logic pause;
	logic [3:0] back;
	logic [7:0] light_r;
	logic [7:0] light_g;
	logic [7:0] light_b;
	logic [2:0] which_col;
	logic [7:0] score_bar;
	logic [6:0] seg;

	step_t steps [0:max_steps-1];
	int nsteps = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;

	breakout_top #(.SCAN_DIV(scan_div), .MOVE_DIV(move_div)) dut (
		.CLK(CLK),
		.reset(reset),
		.sw_l(sw_l),
		.sw_r(sw_r),
		.shoot(shoot),
		.pause(pause),
		.back(back),
		.light_r(light_r),
		.light_g(light_g),
		.light_b(light_b),
		.which_col(which_col),
		.score_bar(score_bar),
		.seg(seg)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("ERROR: timeout after %0d cycles, the steps did not finish", cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic add_step(input logic [3:0] keys, input logic [3:0] bk, input int ticks,
		input int lay, input logic clr, input int pad, input int bx, input int by,
		input logic [7:0] bar, input int digit);
		{steps[nsteps].sw_l, steps[nsteps].sw_r, steps[nsteps].shoot, steps[nsteps].pause} = keys;
		steps[nsteps].back = bk;
		steps[nsteps].ticks = ticks;
		steps[nsteps].lay = lay;
		steps[nsteps].clr = clr;
		steps[nsteps].pad = pad;
		steps[nsteps].bx = bx;
		steps[nsteps].by = by;
		steps[nsteps].bar = bar;
		steps[nsteps].digit = digit;
		nsteps++;
	endtask

	task automatic load_table();
		add_step(key_pause, 4'b0000, 0, 0, 0, 4, 4, 6, 8'h00, 2); // state after reset
		add_step(key_none, 4'b0010, 3, 2, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_none, 4'b0100, 3, 3, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_none, 4'b1000, 3, 4, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_none, 4'b0001, 3, 1, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_none, 4'b0000, 2, 1, 0, 4, 4, 6, 8'h00, 2); // play, layout 1 kept
		add_step(key_left, 4'b0000, 1, 1, 0, 3, 3, 6, 8'h00, 2);
		add_step(key_left, 4'b0000, 2, 1, 0, 1, 1, 6, 8'h00, 2);
		add_step(key_left, 4'b0000, 3, 1, 0, 1, 1, 6, 8'h00, 2); // left clamp
		add_step(key_right, 4'b0000, 3, 1, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_right, 4'b0000, 5, 1, 0, 6, 6, 6, 8'h00, 2); // right clamp
		add_step(key_both, 4'b0000, 1, 1, 0, 5, 5, 6, 8'h00, 2); // sw_l wins
		add_step(key_pause | key_left, 4'b0000, 20, 1, 0, 5, 5, 6, 8'h00, 2);
		add_step(key_left, 4'b0000, 1, 1, 0, 4, 4, 6, 8'h00, 2);
		add_step(key_shoot, 4'b0000, 2, 1, 0, 4, 4, 5, 8'h00, 2);
		add_step(key_none, 4'b0000, 3, 1, 1, 4, 4, 3, 8'h01, 2); // hits (4,2)
		add_step(key_left, 4'b0000, 5, 1, 1, 1, 1, 6, 8'h01, 1); // ball lost
	endtask

	function automatic logic layout_bit(input int lay, input int x, input int y);
		logic b;
		case (lay)
			1: b = (y == 2);
			2: b = (y == 0) || (y == 3);
			3: b = (y <= 3);
			4:
			begin
				case (x)
					0, 1, 6, 7: b = (y == 1);
					2, 5: b = (y == 2);
					default: b = (y >= 1) && (y <= 3);
				endcase
			end
			default: b = 1'b0;
		endcase
		return b;
	endfunction

	// {r, g, b}, a lit colour is a 0
	function automatic logic [23:0] expected_column(input step_t s, input int c);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic brick;
		logic pad;
		logic ball;
		for (int y = 0; y < 8; y++)
		begin
			brick = layout_bit(s.lay, c, y) && !(s.clr && c == 4 && y == 2);
			pad = (y == 7) && (c >= int'(s.pad) - 1) && (c <= int'(s.pad) + 1);
			ball = (c == int'(s.bx)) && (y == int'(s.by));
			r[y] = !ball;
			g[y] = !(ball || brick);
			b[y] = !(ball || brick || pad);
		end
		return {r, g, b};
	endfunction

	// a in bit 6, g in bit 0
	function automatic logic [6:0] seg_pattern(input int digit);
		logic [6:0] p;
		case (digit)
			0: p = 7'b0000001;
			1: p = 7'b1001111;
			default: p = 7'b0010010;
		endcase
		return p;
	endfunction

	task automatic check_scan();
		int prev;
		int wraps;
		@(negedge CLK);
		checks++;
		if (which_col !== 3'd0)
		begin
			errors++;
			$display("MISMATCH at %0t: which_col %0d after reset, expected 0", $time, which_col);
		end
		prev = 0;
		wraps = 0;
		repeat (24)
		begin
			@(negedge CLK);
			if (int'(which_col) != prev)
			begin
				checks++;
				if (int'(which_col) != (prev + 1) % 8)
				begin
					errors++;
					$display("MISMATCH at %0t: which_col %0d after %0d", $time, which_col, prev);
				end
				if (prev == 7)
					wraps++;
				prev = which_col;
			end
		end
		if (wraps == 0)
		begin
			errors++;
			$display("ERROR: which_col never wrapped from 7 to 0");
		end
	endtask

	task automatic check_frame(input step_t s, input int row);
		int start;
		int c;
		logic [23:0] want;
		logic [23:0] got;
		start = which_col;
		for (int k = 0; k < 8; k++)
		begin
			c = (start + k) % 8;
			while (int'(which_col) != c)
				@(negedge CLK);
			want = expected_column(s, c);
			got = {light_r, light_g, light_b};
			checks++;
			if (got !== want)
			begin
				errors++;
				$display("MISMATCH at %0t: step %0d col %0d rgb %h/%h/%h, expected %h/%h/%h",
					$time, row, c, got[23:16], got[15:8], got[7:0],
					want[23:16], want[15:8], want[7:0]);
			end
		end
		checks++;
		if (score_bar !== s.bar)
		begin
			errors++;
			$display("MISMATCH at %0t: step %0d score_bar %b, expected %b", $time, row,
				score_bar, s.bar);
		end
		checks++;
		if (seg !== seg_pattern(s.digit))
		begin
			errors++;
			$display("MISMATCH at %0t: step %0d seg %b, expected digit %0d", $time, row, seg,
				s.digit);
		end
	endtask

	task automatic run_step(input step_t s, input int row);
		int seen;
		int paused_ticks;
		@(posedge CLK);
		sw_l <= s.sw_l;
		sw_r <= s.sw_r;
		shoot <= s.shoot;
		pause <= s.pause;
		back <= s.back;
		seen = 0;
		paused_ticks = 0;
		if (s.pause)
		begin
			repeat (s.ticks * move_div)
			begin
				@(negedge CLK);
				if (dut.move_tick)
					paused_ticks++;
			end
			if (paused_ticks != 0)
			begin
				errors++;
				$display("ERROR: %0d move ticks came through while paused in step %0d",
					paused_ticks, row);
			end
		end
		else
		begin
			while (seen < s.ticks)
			begin
				@(negedge CLK);
				if (dut.move_tick)
					seen++;
			end
		end
		@(posedge CLK);
		sw_l <= 1'b0;
		sw_r <= 1'b0;
		shoot <= 1'b0;
		pause <= 1'b1; // game holds still while the frame is read
		@(negedge CLK);
		check_frame(s, row);
	endtask

	initial
	begin
		int total;
		reset = 1'b0;
		sw_l = 1'b0;
		sw_r = 1'b0;
		shoot = 1'b0;
		pause = 1'b1;
		back = 4'b0000;
		load_table();
		total = 0;
		for (int i = 0; i < nsteps; i++)
			total += steps[i].ticks;
		limit = 2 * total * move_div + 200;
		repeat (16) @(posedge CLK);
		reset <= 1'b1;
		check_scan();
		for (int i = 0; i < nsteps; i++)
			run_step(steps[i], i);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+include
hw/breakout_pkg.sv
hw/tick_divider.sv
hw/brick_field.sv
hw/ball_engine.sv
hw/matrix_scan.sv
hw/status_display.sv
hw/breakout_top.sv
dv/breakout_tb.sv

/* hw/ball_engine.sv */
`timescale 1ns/10ps
`include "breakout_macros.svh"

module ball_engine
	import breakout_pkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       move_tick,
	input  logic       setup,
	input  logic       sw_l,
	input  logic       sw_r,
	input  logic       shoot,
	input  grid_u      bricks,
	output brick_hit_t hit,
	output sprite_t    sprite,
	output logic [3:0] score,
	output logic [1:0] lives,
	output logic       win
);
	coord_t paddle;
	coord_t ball_x;
	coord_t ball_y;
	dir_t dir;
	logic rest; // ball sits on the paddle

	coord_t new_pad;
	coord_t next_x;
	coord_t next_y;
	logic go_up;
	logic go_left;
	logic go_right;
	logic over_pad;
	logic lose;
	logic brick_ahead;
	dir_t fly_dir;
	dir_t turn_dir;

	function automatic dir_t make_dir(input logic up, input logic left, input logic right);
		dir_t d;
		if (up)
			d = left ? dir_up_left : (right ? dir_up_right : dir_up);
		else
			d = left ? dir_down_left : (right ? dir_down_right : dir_down);
		return d;
	endfunction

	always_comb
	begin
		new_pad = paddle;
		if (sw_l && paddle >= 3'd2)
			new_pad = paddle - 1'b1; // left wins
		else if (sw_r && paddle <= 3'(`GRID_N - 3))
			new_pad = paddle + 1'b1;

		go_up = (dir == dir_up) || (dir == dir_up_left) || (dir == dir_up_right);
		go_left = (dir == dir_up_left) || (dir == dir_down_left);
		go_right = (dir == dir_up_right) || (dir == dir_down_right);

		// paddle sits one row below the ball
		over_pad = !go_up && (ball_y == 3'(`PADDLE_ROW - 1)) &&
			(ball_x == paddle || ball_x == paddle - 1'b1 || ball_x == paddle + 1'b1);
		lose = !go_up && (ball_y == 3'(`PADDLE_ROW - 1)) && !over_pad;

		if (over_pad)
		begin
			go_up = 1'b1;
			go_left = (ball_x == paddle - 1'b1);
			go_right = (ball_x == paddle + 1'b1);
		end

		if (go_up && ball_y == 3'd0)
			go_up = 1'b0; // ceiling
		if (go_left && ball_x == 3'd0)
		begin
			go_left = 1'b0;
			go_right = 1'b1;
		end
		else if (go_right && ball_x == 3'(`GRID_N - 1))
		begin
			go_right = 1'b0;
			go_left = 1'b1;
		end

		next_x = go_left ? ball_x - 1'b1 : (go_right ? ball_x + 1'b1 : ball_x);
		next_y = go_up ? ball_y - 1'b1 : ball_y + 1'b1;
		brick_ahead = !lose && bricks.col[next_x][next_y];
		fly_dir = make_dir(go_up, go_left, go_right);
		turn_dir = make_dir(!go_up, go_left, go_right); // bounce off brick in place
	end

	always_ff @(posedge CLK)
	begin
		if (!reset)
		begin
			paddle <= coord_t'(`SERVE_X);
			ball_x <= coord_t'(`SERVE_X);
			ball_y <= coord_t'(`SERVE_Y);
			dir <= dir_up;
			rest <= 1'b1;
			score <= 4'd0;
			lives <= 2'(`START_LIVES);
			win <= 1'b0;
		end
		else if (move_tick)
		begin
			if (setup)
			begin
				paddle <= coord_t'(`SERVE_X);
				ball_x <= coord_t'(`SERVE_X);
				ball_y <= coord_t'(`SERVE_Y);
				dir <= dir_up;
				rest <= 1'b1;
				score <= 4'd0;
				lives <= 2'(`START_LIVES);
				win <= 1'b0;
			end
			else
			begin
				paddle <= new_pad;
				if (rest)
				begin
					ball_x <= new_pad; // follow the paddle
					if (shoot)
					begin
						rest <= 1'b0;
						dir <= dir_up;
						win <= 1'b0;
					end
				end
				else if (lose)
				begin
					rest <= 1'b1;
					ball_x <= new_pad;
					ball_y <= coord_t'(`SERVE_Y);
					dir <= dir_up;
					if (lives == 2'd0)
					begin
						lives <= 2'(`START_LIVES);
						score <= 4'd0;
					end
					else
						lives <= lives - 1'b1;
				end
				else if (brick_ahead)
				begin
					dir <= turn_dir;
					if (score == 4'(`WIN_SCORE - 1))
					begin
						score <= 4'd0;
						win <= 1'b1;
						rest <= 1'b1; // serve again
						ball_x <= new_pad;
						ball_y <= coord_t'(`SERVE_Y);
						dir <= dir_up;
					end
					else
						score <= score + 1'b1;
				end
				else
				begin
					ball_x <= next_x;
					ball_y <= next_y;
					dir <= fly_dir;
				end
			end
		end
	end

	// field clears on the same tick
	assign hit.valid = move_tick && !setup && !rest && brick_ahead;
	assign hit.x = next_x;
	assign hit.y = next_y;

	assign sprite.ball_x = ball_x;
	assign sprite.ball_y = ball_y;
	assign sprite.paddle = paddle;
	assign sprite.ball_vis = !win; // hidden while the win bar shows

endmodule

/* hw/breakout_pkg.sv */
`include "breakout_macros.svh"

package breakout_pkg;

	// one column or row index
	typedef logic [`COORD_W-1:0] coord_t;

	typedef enum logic [2:0] {
		dir_up,
		dir_up_left,
		dir_up_right,
		dir_down,
		dir_down_left,
		dir_down_right
	} dir_t;

	// flat for whole-layout loads, col[x][y] for scan and look-up
	typedef union packed {
		logic [`GRID_N*`GRID_N-1:0] flat;
		logic [`GRID_N-1:0][`GRID_N-1:0] col;
	} grid_u;

	// one brick to clear
	typedef struct packed {
		logic valid;
		coord_t x;
		coord_t y;
	} brick_hit_t;

	typedef struct packed {
		coord_t ball_x;
		coord_t ball_y;
		coord_t paddle; // centre cell
		logic ball_vis;
	} sprite_t;

endpackage

/* hw/breakout_top.sv */
`timescale 1ns/10ps
`include "breakout_macros.svh"

module breakout_top
	import breakout_pkg::*;
#(
	parameter int SCAN_DIV = `SCAN_DIV,
	parameter int MOVE_DIV = `MOVE_DIV
) (
	input  logic              CLK,
	input  logic              reset,
	input  logic              sw_l,
	input  logic              sw_r,
	input  logic              shoot,
	input  logic              pause,
	input  logic [3:0]        back,
	output logic [7:0]        light_r,
	output logic [7:0]        light_g,
	output logic [7:0]        light_b,
	output coord_t            which_col,
	output logic [7:0]        score_bar,
	output logic [`SEG_W-1:0] seg
);
	logic scan_tick;
	logic move_tick;
	logic setup;
	grid_u bricks;
	brick_hit_t hit;
	sprite_t sprite;
	logic [3:0] score;
	logic [1:0] lives;
	logic win;

	tick_divider #(.DIV(SCAN_DIV)) u_scan_div (
		.CLK(CLK),
		.reset(reset),
		.hold(1'b0),
		.tick(scan_tick)
	);

	tick_divider #(.DIV(MOVE_DIV)) u_move_div (
		.CLK(CLK),
		.reset(reset),
		.hold(pause), // pause freezes the game
		.tick(move_tick)
	);

	brick_field u_field (
		.CLK(CLK),
		.reset(reset),
		.move_tick(move_tick),
		.back(back),
		.hit(hit),
		.bricks(bricks),
		.setup(setup)
	);

	ball_engine u_engine (
		.CLK(CLK),
		.reset(reset),
		.move_tick(move_tick),
		.setup(setup),
		.sw_l(sw_l),
		.sw_r(sw_r),
		.shoot(shoot),
		.bricks(bricks),
		.hit(hit),
		.sprite(sprite),
		.score(score),
		.lives(lives),
		.win(win)
	);

	matrix_scan u_scan (
		.CLK(CLK),
		.reset(reset),
		.scan_tick(scan_tick),
		.bricks(bricks),
		.sprite(sprite),
		.which_col(which_col),
		.light_r(light_r),
		.light_g(light_g),
		.light_b(light_b)
	);

	status_display u_status (
		.score(score),
		.win(win),
		.lives(lives),
		.score_bar(score_bar),
		.seg(seg)
	);

endmodule

/* hw/brick_field.sv */
`timescale 1ns/10ps
`include "breakout_macros.svh"

module brick_field
	import breakout_pkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       move_tick,
	input  logic [3:0] back,
	input  brick_hit_t hit,
	output grid_u      bricks,
	output logic       setup
);
	logic [2:0] mode; // 0 play, 1 to 4 layout
	logic [2:0] next_mode;
	logic [`GRID_N*`GRID_N-1:0] layout_word;

	// one-hot back picks a layout, other codes keep the mode
	always_comb
	begin
		case (back)
			4'b0000: next_mode = 3'd0;
			4'b0001: next_mode = 3'd1;
			4'b0010: next_mode = 3'd2;
			4'b0100: next_mode = 3'd3;
			4'b1000: next_mode = 3'd4;
			default: next_mode = mode;
		endcase
	end

	// column x sits in byte x, row y in bit y
	always_comb
	begin
		case (next_mode)
			3'd1: layout_word = {`GRID_N{8'b0000_0100}}; // row 2
			3'd2: layout_word = {`GRID_N{8'b0000_1001}}; // rows 0 and 3
			3'd3: layout_word = {`GRID_N{8'b0000_1111}}; // rows 0 to 3
			3'd4: layout_word = 64'h0202_040e_0e04_0202; // pyramid
			default: layout_word = '0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!reset)
		begin
			mode <= 3'd0;
			bricks.flat <= '0;
		end
		else if (move_tick)
		begin
			mode <= next_mode;
			if (next_mode != 3'd0)
				bricks.flat <= layout_word; // reload while selected
			else if (hit.valid)
				bricks.col[hit.x][hit.y] <= 1'b0;
		end
	end

	assign setup = (mode != 3'd0);

endmodule

/* hw/matrix_scan.sv */
`timescale 1ns/10ps
`include "breakout_macros.svh"

module matrix_scan
	import breakout_pkg::*;
(
	input  logic              CLK,
	input  logic              reset,
	input  logic              scan_tick,
	input  grid_u             bricks,
	input  sprite_t           sprite,
	output coord_t            which_col,
	output logic [`GRID_N-1:0] light_r,
	output logic [`GRID_N-1:0] light_g,
	output logic [`GRID_N-1:0] light_b
);
	logic [`GRID_N-1:0] col_bricks;
	logic [`GRID_N-1:0] pad_bits;
	logic [`GRID_N-1:0] ball_bits;

	always_ff @(posedge CLK)
	begin
		if (!reset)
			which_col <= '0;
		else if (scan_tick)
			which_col <= which_col + 1'b1; // wraps at 8
	end

	always_comb
	begin
		col_bricks = bricks.col[which_col];
		pad_bits = '0;
		ball_bits = '0;
		if (which_col == sprite.paddle || which_col == sprite.paddle - 1'b1 ||
			which_col == sprite.paddle + 1'b1)
			pad_bits[`PADDLE_ROW] = 1'b1;
		if (sprite.ball_vis && sprite.ball_x == which_col)
			ball_bits[sprite.ball_y] = 1'b1;
	end

	// brick cyan, paddle blue, ball white on top
	assign light_r = ~ball_bits;
	assign light_g = ~(col_bricks | ball_bits);
	assign light_b = ~(col_bricks | pad_bits | ball_bits);

endmodule

/* hw/status_display.sv */
`timescale 1ns/10ps
`include "breakout_macros.svh"

module status_display (
	input  logic [3:0]        score,
	input  logic              win,
	input  logic [1:0]        lives,
	output logic [7:0]        score_bar,
	output logic [`SEG_W-1:0] seg
);

	// thermometer, full on a win
	always_comb
	begin
		for (int i = 0; i < 8; i++)
			score_bar[i] = win || (score > 4'(i));
	end

	// seg[6] is a, seg[0] is g
	always_comb
	begin
		case (lives)
			2'd0: seg = 7'b0000001;
			2'd1: seg = 7'b1001111;
			2'd2: seg = 7'b0010010;
			default: seg = 7'b1111111; // blank
		endcase
	end

endmodule

/* hw/tick_divider.sv */
`timescale 1ns/10ps

module tick_divider #(
	parameter int DIV = 4
) (
	input  logic CLK,
	input  logic reset,
	input  logic hold,
	output logic tick
);
	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] count;

	always_ff @(posedge CLK)
	begin
		if (!reset)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (hold)
			tick <= 1'b0; // frozen, count kept
		else if (count == CW'(DIV - 1))
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* include/breakout_macros.svh */
`ifndef BREAKOUT_MACROS_SVH
`define BREAKOUT_MACROS_SVH

// matrix geometry
`define GRID_N 8
`define COORD_W 3

// clocks per column step and per game step
`define SCAN_DIV 50000
`define MOVE_DIV 8000000

// paddle row and serve cell on top of the paddle centre
`define PADDLE_ROW 7
`define SERVE_X 4
`define SERVE_Y 6

// spare balls after reset
`define START_LIVES 2

// bricks needed to win
`define WIN_SCORE 8

// a to g, active low
`define SEG_W 7

`endif
